//--- tconv_engine.f
tconv_pkg.sv
batch_scheduler.sv
line_fetch.sv
buffer_arbiter.sv
feature_sram.sv
dot_product_unit.sv
tconv_engine.sv
tb_clock_gen.sv
tb_tconv_engine.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_tconv_engine
RTL_TOP    ?= tconv_engine
FILELIST   ?= tconv_engine.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= Verification passed

SOURCES := $(shell cat $(FILELIST))
RTL_SRC := $(filter-out tb_%,$(SOURCES))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRC)

clean:
	rm -rf $(BUILD_DIR)

//--- tb_tconv_engine.sv
`timescale 1ns/1ps

module tb_tconv_engine;
    import tconv_pkg::*;

    localparam int BATCH_TIMEOUT = 40000;
    localparam int RESET_TIMEOUT = 100;

    logic              clk;
    logic              rst_n;
    logic              start;
    logic [1:0]        layer_id;
    logic [2:0]        batch_id;
    logic              load_en;
    logic [ADDR_W-1:0] load_addr;
    logic [WORD_W-1:0] load_data;
    logic              result_valid;
    logic [ACC_W-1:0]  result;
    logic [TAG_W-1:0]  tile_id;
    logic [TAG_W-1:0]  row_id;
    logic              batch_done;
    logic              busy;

    // Copy of the SRAM contents as loaded by the host
    logic [WORD_W-1:0] mirror [MEM_DEPTH];
    integer            seed;
    int                err_count;
    int                tests_run;
    int                tests_failed;
    bit                timed_out;

    // Monitor state
    logic [1:0]        run_layer;
    logic [2:0]        run_batch_id;
    int                res_count;
    int                done_count;
    bit                exp_busy;
    bit                exp_done;
    bit                done_next;
    logic [31:0]       expv;

    tb_clock_gen u_clk (
        .clk(clk),
        .rst_n(rst_n)
    );

    tconv_engine dut (
        .clk(clk), .rst_n(rst_n), .start(start),
        .layer_id(layer_id), .batch_id(batch_id),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .result_valid(result_valid), .result(result),
        .tile_id(tile_id), .row_id(row_id),
        .batch_done(batch_done), .busy(busy)
    );

    // ============================================================
    // Reference model
    // ============================================================
    function automatic int layer_row_bits(input logic [1:0] layer);
        case (layer)
            2'd0:    return ROW_BITS_L0;
            2'd1:    return ROW_BITS_L1;
            2'd2:    return ROW_BITS_L2;
            default: return ROW_BITS_L3;
        endcase
    endfunction

    function automatic int pass_total(input logic [1:0] layer);
        return TILES_PER_BATCH << layer_row_bits(layer);
    endfunction

    // Packed as tile_id, row_id, result from the top bit down
    function automatic logic [31:0] ref_pass(input logic [1:0] layer,
                                             input logic [2:0] batch, input int pass);
        int               rows;
        int               row;
        int               tile;
        int               base_if;
        int               base_wt;
        logic [ACC_W-1:0] sum;
        rows    = 1 << layer_row_bits(layer);
        row     = pass % rows;
        tile    = pass / rows;
        base_if = row * LINE_WORDS;
        base_wt = WEIGHT_BASE + tile * 256 + (row % 16) * LINE_WORDS;
        sum     = '0;
        for (int k = 0; k < LINE_WORDS; k++)
            sum = sum + ACC_W'(mirror[ADDR_W'(base_if + k)])
                      * ACC_W'(mirror[ADDR_W'(base_wt + k)]);
        return {TAG_W'({batch, 2'(tile)}), TAG_W'(row), sum};
    endfunction

    // ============================================================
    // Monitor and comparator, sampled mid-cycle
    // ============================================================
    always @(negedge clk) begin
        if (rst_n) begin
            assert (busy === exp_busy) else begin
                $display("** Error at %0t: busy is %b, expected %b", $time, busy, exp_busy);
                err_count++;
            end
            assert (batch_done === exp_done) else begin
                $display("** Error at %0t: batch_done is %b, expected %b",
                         $time, batch_done, exp_done);
                err_count++;
            end
            done_next = 1'b0;
            if (result_valid === 1'b1) begin
                assert (exp_busy) else begin
                    $display("** Error at %0t: result_valid with no batch running", $time);
                    err_count++;
                end
                expv = ref_pass(run_layer, run_batch_id, res_count);
                assert (result === expv[ACC_W-1:0] && row_id === expv[ACC_W +: TAG_W]
                        && tile_id === expv[ACC_W+TAG_W +: TAG_W]) else begin
                    $display("** Error at %0t: pass %0d got tile %h row %0d result %0d, %s",
                             $time, res_count, tile_id, row_id, result, "mismatch");
                    $display("** Error at %0t: pass %0d expected tile %h row %0d result %0d",
                             $time, res_count, expv[ACC_W+TAG_W +: TAG_W],
                             expv[ACC_W +: TAG_W], expv[ACC_W-1:0]);
                    err_count++;
                end
                res_count++;
                // Last pass of the layer, busy drops with batch_done next cycle
                if (res_count == pass_total(run_layer)) begin
                    exp_busy  = 1'b0;
                    done_next = 1'b1;
                end
            end
            if (batch_done === 1'b1)
                done_count++;
            exp_done = done_next;
            if (start === 1'b1 && busy === 1'b0) begin
                run_layer    = layer_id;
                run_batch_id = batch_id;
                res_count    = 0;
                done_count   = 0;
                exp_busy     = 1'b1;
            end
        end
    end

    // ============================================================
    // Stimulus tasks
    // ============================================================
    task automatic wait_for_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < RESET_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("%s: ok (%0d results)", name, res_count);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, err_count - errs_before);
        end
    endtask

    // Host writes random bytes, mirror follows
    task automatic load_region(input int first, input int count);
        integer val;
        if (!timed_out) begin
            for (int a = first; a < first + count; a++) begin
                @(posedge clk);
                val = $random(seed);
                load_en   <= 1'b1;
                load_addr <= ADDR_W'(a);
                load_data <= WORD_W'(val);
                mirror[ADDR_W'(a)] = WORD_W'(val);
            end
            @(posedge clk);
            load_en <= 1'b0;
        end
    endtask

    task automatic check_idle(input string name, input int cycles);
        int errs_before;
        if (!timed_out) begin
            errs_before = err_count;
            res_count   = 0;
            repeat (cycles) @(posedge clk);
            report_test(name, errs_before);
        end
    endtask

    task automatic run_batch(input logic [1:0] layer, input logic [2:0] batch,
                             input bit extra_start, input string name);
        int errs_before;
        int n;
        if (!timed_out) begin
            errs_before = err_count;
            @(posedge clk);
            layer_id <= layer;
            batch_id <= batch;
            start    <= 1'b1;
            @(posedge clk);
            start    <= 1'b0;
            if (extra_start) begin
                // Second start in the middle of the first pass, other context
                repeat (40) @(posedge clk);
                layer_id <= ~layer;
                batch_id <= ~batch;
                start    <= 1'b1;
                @(posedge clk);
                start    <= 1'b0;
            end
            n = 0;
            while (done_count == 0 && n < BATCH_TIMEOUT) begin
                @(posedge clk);
                n++;
            end
            if (done_count == 0) begin
                $display("Timeout: %s never signalled batch_done within %0d cycles",
                         name, BATCH_TIMEOUT);
                timed_out = 1'b1;
            end else begin
                // Quiet tail, the monitor flags any stray strobe
                repeat (20) @(posedge clk);
                assert (res_count == pass_total(layer)) else begin
                    $display("** Error at %0t: %s gave %0d results, expected %0d",
                             $time, name, res_count, pass_total(layer));
                    err_count++;
                end
                assert (done_count == 1) else begin
                    $display("** Error at %0t: %s saw %0d batch_done pulses",
                             $time, name, done_count);
                    err_count++;
                end
                report_test(name, errs_before);
            end
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        start        = 1'b0;
        layer_id     = '0;
        batch_id     = '0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        seed         = 32'h41a6870b;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        run_layer    = '0;
        run_batch_id = '0;
        res_count    = 0;
        done_count   = 0;
        exp_busy     = 1'b0;
        exp_done     = 1'b0;
        done_next    = 1'b0;

        wait_for_reset();
        check_idle("idle after reset", 20);
        load_region(0, MEM_DEPTH);

        run_batch(2'd0, 3'd0, 1'b0, "layer 0 batch 0");
        run_batch(2'd1, 3'd5, 1'b0, "layer 1 batch 5");
        run_batch(2'd2, 3'd2, 1'b0, "layer 2 batch 2");
        run_batch(2'd3, 3'd3, 1'b0, "layer 3 batch 3");
        run_batch(2'd2, 3'd1, 1'b1, "start while busy");
        check_idle("idle between batches", 20);

        // New ifmap rows and tile 0 weights
        load_region(0, 128);
        load_region(WEIGHT_BASE, 256);
        run_batch(2'd3, 3'd6, 1'b0, "layer 3 after reload");

        $display("Tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, err_count);
        if (!timed_out && err_count == 0 && tests_failed == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for 8 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tconv_engine.sv
`timescale 1ns/1ps

module tconv_engine (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [1:0]                   layer_id,
    input  logic [2:0]                   batch_id,
    input  logic                         load_en,
    input  logic [tconv_pkg::ADDR_W-1:0] load_addr,
    input  logic [tconv_pkg::WORD_W-1:0] load_data,
    output logic                         result_valid,
    output logic [tconv_pkg::ACC_W-1:0]  result,
    output logic [tconv_pkg::TAG_W-1:0]  tile_id,
    output logic [tconv_pkg::TAG_W-1:0]  row_id,
    output logic                         batch_done,
    output logic                         busy
);
    import tconv_pkg::*;

    logic                  fetch_start;
    logic [ADDR_W-1:0]     if_base;
    logic [ADDR_W-1:0]     wt_base;
    logic                  mac_start;
    logic                  mac_done;

    // Fetcher side of the arbiter
    logic                  if_req, wt_req;
    logic [ADDR_W-1:0]     if_addr, wt_addr;
    logic                  if_gnt, wt_gnt;
    logic                  if_rvalid, wt_rvalid;
    logic                  if_done, wt_done;
    logic [LINE_WORDS-1:0][WORD_W-1:0] if_line;
    logic [LINE_WORDS-1:0][WORD_W-1:0] wt_line;

    // SRAM port
    logic                  mem_we;
    logic [ADDR_W-1:0]     mem_addr;
    logic [WORD_W-1:0]     mem_wdata;
    logic [WORD_W-1:0]     mem_rdata;

    assign result_valid = mac_done;

    batch_scheduler u_sched (
        .clk(clk), .rst_n(rst_n), .start(start),
        .layer_id(layer_id), .batch_id(batch_id),
        .fetch_done_if(if_done), .fetch_done_wt(wt_done), .mac_done(mac_done),
        .fetch_start(fetch_start), .if_base(if_base), .wt_base(wt_base),
        .mac_start(mac_start), .tile_id(tile_id), .row_id(row_id),
        .busy(busy), .batch_done(batch_done)
    );

    line_fetch u_if_fetch (
        .clk(clk), .rst_n(rst_n), .start(fetch_start), .base(if_base),
        .req(if_req), .addr(if_addr), .gnt(if_gnt), .rvalid(if_rvalid),
        .rdata(mem_rdata), .done(if_done), .line(if_line)
    );

    line_fetch u_wt_fetch (
        .clk(clk), .rst_n(rst_n), .start(fetch_start), .base(wt_base),
        .req(wt_req), .addr(wt_addr), .gnt(wt_gnt), .rvalid(wt_rvalid),
        .rdata(mem_rdata), .done(wt_done), .line(wt_line)
    );

    buffer_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .req_a(if_req), .addr_a(if_addr), .req_b(wt_req), .addr_b(wt_addr),
        .gnt_a(if_gnt), .gnt_b(wt_gnt), .rvalid_a(if_rvalid), .rvalid_b(wt_rvalid),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    feature_sram u_sram (
        .clk(clk), .we(mem_we), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
    );

    dot_product_unit u_dpu (
        .clk(clk), .rst_n(rst_n), .start(mac_start),
        .line_a(if_line), .line_b(wt_line), .result(result), .done(mac_done)
    );

endmodule

//--- dot_product_unit.sv
`timescale 1ns/1ps

module dot_product_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic [tconv_pkg::LINE_WORDS-1:0][tconv_pkg::WORD_W-1:0] line_a,
    input  logic [tconv_pkg::LINE_WORDS-1:0][tconv_pkg::WORD_W-1:0] line_b,
    output logic [tconv_pkg::ACC_W-1:0]       result,
    output logic                              done
);
    import tconv_pkg::*;

    logic                  running;
    logic [LINE_IDX_W-1:0] k;
    logic [2*WORD_W-1:0]   prod;
    logic [ACC_W-1:0]      acc;

    assign prod   = (2*WORD_W)'(line_a[k]) * (2*WORD_W)'(line_b[k]);
    assign result = acc;

    // ============================================================
    // Term counter, one product per cycle
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            k       <= '0;
            done    <= 1'b0;
        end else begin
            done <= running && (k == LINE_IDX_W'(LINE_WORDS - 1));
            if (start) begin
                running <= 1'b1;
                k       <= '0;
            end else if (running) begin
                k <= k + 1'b1;
                if (k == LINE_IDX_W'(LINE_WORDS - 1))
                    running <= 1'b0;
            end
        end
    end

    // Accumulator holds the sum until the next start
    always_ff @(posedge clk) begin
        if (start)
            acc <= '0;
        else if (running)
            acc <= acc + ACC_W'(prod);
    end

endmodule

//--- feature_sram.sv
`timescale 1ns/1ps

module feature_sram (
    input  logic                         clk,
    input  logic                         we,
    input  logic [tconv_pkg::ADDR_W-1:0] addr,
    input  logic [tconv_pkg::WORD_W-1:0] wdata,
    output logic [tconv_pkg::WORD_W-1:0] rdata
);
    import tconv_pkg::*;

    logic [WORD_W-1:0] mem [MEM_DEPTH];

    // Single port, read data registered
    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];
    end

endmodule

//--- buffer_arbiter.sv
`timescale 1ns/1ps

module buffer_arbiter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load_en,
    input  logic [tconv_pkg::ADDR_W-1:0] load_addr,
    input  logic [tconv_pkg::WORD_W-1:0] load_data,
    input  logic                         req_a,
    input  logic [tconv_pkg::ADDR_W-1:0] addr_a,
    input  logic                         req_b,
    input  logic [tconv_pkg::ADDR_W-1:0] addr_b,
    output logic                         gnt_a,
    output logic                         gnt_b,
    output logic                         rvalid_a,
    output logic                         rvalid_b,
    output logic                         mem_we,
    output logic [tconv_pkg::ADDR_W-1:0] mem_addr,
    output logic [tconv_pkg::WORD_W-1:0] mem_wdata
);
    import tconv_pkg::*;

    logic              prio_b;
    logic [ADDR_W-1:0] fetch_addr;

    // Host load always wins, then round robin between fetchers
    assign gnt_a = !load_en && req_a && (!req_b || !prio_b);
    assign gnt_b = !load_en && req_b && (!req_a || prio_b);

    assign fetch_addr = gnt_b ? addr_b : addr_a;
    assign mem_we     = load_en;
    assign mem_addr   = load_en ? load_addr : fetch_addr;
    assign mem_wdata  = load_data;

    // Read data lands one cycle after the grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_b   <= 1'b0;
            rvalid_a <= 1'b0;
            rvalid_b <= 1'b0;
        end else begin
            rvalid_a <= gnt_a;
            rvalid_b <= gnt_b;
            if (gnt_a)
                prio_b <= 1'b1;
            else if (gnt_b)
                prio_b <= 1'b0;
        end
    end

endmodule

//--- line_fetch.sv
`timescale 1ns/1ps

module line_fetch (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic [tconv_pkg::ADDR_W-1:0]      base,
    output logic                              req,
    output logic [tconv_pkg::ADDR_W-1:0]      addr,
    input  logic                              gnt,
    input  logic                              rvalid,
    input  logic [tconv_pkg::WORD_W-1:0]      rdata,
    output logic                              done,
    output logic [tconv_pkg::LINE_WORDS-1:0][tconv_pkg::WORD_W-1:0] line
);
    import tconv_pkg::*;

    logic [ADDR_W-1:0]     base_q;
    logic [LINE_IDX_W:0]   issue_cnt;
    logic [LINE_IDX_W-1:0] rx_cnt;

    // Idle once all addresses of the line are out
    assign req  = (issue_cnt != (LINE_IDX_W + 1)'(LINE_WORDS));
    assign addr = base_q + ADDR_W'(issue_cnt[LINE_IDX_W-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_cnt <= (LINE_IDX_W + 1)'(LINE_WORDS);
            rx_cnt    <= '0;
            done      <= 1'b0;
        end else begin
            done <= rvalid && (rx_cnt == LINE_IDX_W'(LINE_WORDS - 1));
            if (start) begin
                issue_cnt <= '0;
                rx_cnt    <= '0;
            end else begin
                if (gnt)
                    issue_cnt <= issue_cnt + 1'b1;
                if (rvalid)
                    rx_cnt <= rx_cnt + 1'b1;
            end
        end
    end

    // Line buffer, filled in arrival order
    always_ff @(posedge clk) begin
        if (start)
            base_q <= base;
        if (rvalid)
            line[rx_cnt] <= rdata;
    end

endmodule

//--- batch_scheduler.sv
`timescale 1ns/1ps

module batch_scheduler (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [1:0]                    layer_id,
    input  logic [2:0]                    batch_id,
    input  logic                          fetch_done_if,
    input  logic                          fetch_done_wt,
    input  logic                          mac_done,
    output logic                          fetch_start,
    output logic [tconv_pkg::ADDR_W-1:0]  if_base,
    output logic [tconv_pkg::ADDR_W-1:0]  wt_base,
    output logic                          mac_start,
    output logic [tconv_pkg::TAG_W-1:0]   tile_id,
    output logic [tconv_pkg::TAG_W-1:0]   row_id,
    output logic                          busy,
    output logic                          batch_done
);
    import tconv_pkg::*;

    sched_state_t      state;
    logic [1:0]        layer_q;
    logic [2:0]        batch_q;
    logic [PASS_W-1:0] pass_cnt;
    logic              if_seen;
    logic              wt_seen;

    logic [2:0]        row_bits;
    logic [PASS_W-1:0] row_mask;
    logic [PASS_W-1:0] last_pass;
    logic [TAG_W-1:0]  row;
    logic [1:0]        tile;

    // ============================================================
    // Layer-aware pass decoding
    // ============================================================
    always_comb begin
        case (layer_q)
            2'd0:    row_bits = 3'(ROW_BITS_L0);
            2'd1:    row_bits = 3'(ROW_BITS_L1);
            2'd2:    row_bits = 3'(ROW_BITS_L2);
            default: row_bits = 3'(ROW_BITS_L3);
        endcase
    end

    assign row_mask  = PASS_W'((1 << row_bits) - 1);
    assign last_pass = PASS_W'((TILES_PER_BATCH << row_bits) - 1);
    assign row       = TAG_W'(pass_cnt & row_mask);
    assign tile      = 2'(pass_cnt >> row_bits);

    assign tile_id = TAG_W'({batch_q, tile});
    assign row_id  = row;

    // One line per row, weight lines repeat every 16 rows inside a tile
    assign if_base = ADDR_W'(row * LINE_WORDS);
    assign wt_base = ADDR_W'(WEIGHT_BASE + tile * LINE_WORDS * LINE_WORDS
                             + row[3:0] * LINE_WORDS);

    // ============================================================
    // Pass sequencing
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            layer_q  <= '0;
            batch_q  <= '0;
            pass_cnt <= '0;
            if_seen  <= 1'b0;
            wt_seen  <= 1'b0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        layer_q  <= layer_id;
                        batch_q  <= batch_id;
                        pass_cnt <= '0;
                        state    <= FETCH;
                    end else begin
                        state <= IDLE;
                    end
                end
                FETCH: begin
                    if_seen <= 1'b0;
                    wt_seen <= 1'b0;
                    state   <= WAIT_FETCH;
                end
                WAIT_FETCH: begin
                    // Fetchers finish in either order
                    if (fetch_done_if)
                        if_seen <= 1'b1;
                    if (fetch_done_wt)
                        wt_seen <= 1'b1;
                    if ((if_seen || fetch_done_if) && (wt_seen || fetch_done_wt))
                        state <= COMPUTE;
                end
                COMPUTE: state <= WAIT_COMPUTE;
                WAIT_COMPUTE: begin
                    if (mac_done) begin
                        if (pass_cnt == last_pass) begin
                            state <= DONE;
                        end else begin
                            pass_cnt <= pass_cnt + 1'b1;
                            state    <= FETCH;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Strobes decoded straight from the state
    assign fetch_start = (state == FETCH);
    assign mac_start   = (state == COMPUTE);
    assign batch_done  = (state == DONE);
    assign busy        = (state != IDLE) && (state != DONE);

endmodule

//--- tconv_pkg.sv
package tconv_pkg;

    // ============================================================
    // Memory geometry
    // ============================================================
    localparam int WORD_W      = 8;
    localparam int ADDR_W      = 11;
    localparam int MEM_DEPTH   = 2048;
    localparam int LINE_WORDS  = 16;
    localparam int LINE_IDX_W  = $clog2(LINE_WORDS);

    // Ifmap lives below this address, weights from here up
    localparam int WEIGHT_BASE = 1024;

    // ============================================================
    // Layer configuration
    // ============================================================
    localparam int TILES_PER_BATCH = 4;
    localparam int PASS_W          = 8;
    localparam int TAG_W           = 6;

    // Row index width per layer, rows per tile is 2**bits
    localparam int ROW_BITS_L0 = 5;
    localparam int ROW_BITS_L1 = 6;
    localparam int ROW_BITS_L2 = 4;
    localparam int ROW_BITS_L3 = 3;

    // Sum of 16 products of two 8-bit words
    localparam int ACC_W = 20;

    // Scheduler FSM
    typedef enum logic [2:0] {
        IDLE, FETCH, WAIT_FETCH, COMPUTE, WAIT_COMPUTE, DONE
    } sched_state_t;

endpackage
